// ==== hdl/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch side and memory side widths.
`define ADDR_W 32
`define WORD_W 32

// line and set geometry.
`define LINE_W 128
`define WORDS_PER_LINE 4
`define WAYS 4
`define SETS 64

// address fields: tag 31:10, index 9:4, word offset 3:2.
`define INDEX_W 6
`define INDEX_LSB 4
`define TAG_W 22
`define TAG_LSB 10
`define OFFSET_MSB 3
`define OFFSET_LSB 2

`endif

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_ctrl (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input logic [`ADDR_W-1:0] fetch_addr,
	input logic inst_ready,
	input logic flush,
	input icache_pkg::way_sel_t hit_way,
	input icache_pkg::way_sel_t victim_way,
	input logic [`LINE_W-1:0] rdata0,
	input logic [`LINE_W-1:0] rdata1,
	input logic [`LINE_W-1:0] rdata2,
	input logic [`LINE_W-1:0] rdata3,
	icache_refill_if.ctrl rf,
	output logic fetch_ready,
	output logic inst_valid,
	output logic [`WORD_W-1:0] inst,
	output icache_pkg::way_sel_t way_en,
	output logic way_we,
	output logic [`INDEX_W-1:0] ram_index,
	output logic fill,
	output icache_pkg::way_sel_t fill_way,
	output logic [`ADDR_W-1:0] fill_addr,
	output logic [`LINE_W-1:0] line_wdata
);

	import icache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic [`ADDR_W-1:0] addr_q;
	way_sel_t sel_way;
	logic [`LINE_W-1:0] miss_line;
	logic drop;
	logic start_q;

	logic resp_free;
	logic accept;
	logic miss;
	logic done_now;
	logic load;
	logic [`LINE_W-1:0] hit_line;
	logic [`LINE_W-1:0] src_line;

	assign resp_free = !inst_valid || inst_ready;
	// no request is taken in a flush cycle.
	assign fetch_ready = (state == IDLE || state == LOOKUP_HIT) && !rf.busy && resp_free && !flush;
	assign accept = fetch_valid && fetch_ready;
	assign miss = accept && (hit_way == '0);
	assign done_now = (state == REFILL) && rf.done;
	assign load = !flush && resp_free &&
		((state == LOOKUP_HIT) || (state == RESPOND_MISS) || (done_now && !drop));

	// the refill writes the victim way; otherwise a hit reads its own way.
	assign fill = done_now;
	assign fill_way = victim_way;
	assign fill_addr = addr_q;
	assign way_we = done_now;
	assign way_en = done_now ? victim_way : (accept ? hit_way : '0);
	assign ram_index = done_now ? addr_q[`INDEX_LSB +: `INDEX_W] :
		fetch_addr[`INDEX_LSB +: `INDEX_W];
	assign line_wdata = rf.line;

	assign rf.start = start_q;
	assign rf.addr = addr_q;

	always_comb begin
		case (sel_way)
			4'b0001: hit_line = rdata0;
			4'b0010: hit_line = rdata1;
			4'b0100: hit_line = rdata2;
			4'b1000: hit_line = rdata3;
			default: hit_line = '0;
		endcase
	end

	always_comb begin
		case (state)
			REFILL: src_line = rf.line;
			RESPOND_MISS: src_line = miss_line;
			default: src_line = hit_line;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, LOOKUP_HIT: begin
				if (flush) begin
					state_nxt = IDLE;
				end else if (miss) begin
					state_nxt = REFILL;
				end else if (accept) begin
					state_nxt = LOOKUP_HIT;
				end else if (resp_free) begin
					state_nxt = IDLE;
				end
			end
			REFILL: begin
				// a stalled response register parks the fresh line in miss_line.
				if (rf.done) begin
					state_nxt = (drop || flush || resp_free) ? IDLE : RESPOND_MISS;
				end
			end
			RESPOND_MISS: begin
				if (flush || resp_free) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			inst_valid <= 1'b0;
			start_q <= 1'b0;
			drop <= 1'b0;
		end else begin
			state <= state_nxt;
			start_q <= miss;
			if (flush) begin
				inst_valid <= 1'b0;
			end else if (load) begin
				inst_valid <= 1'b1;
			end else if (inst_ready) begin
				inst_valid <= 1'b0;
			end
			if (miss) begin
				drop <= 1'b0;
			end else if (flush && state == REFILL) begin
				drop <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= fetch_addr;
			sel_way <= hit_way;
		end
		if (done_now) begin
			miss_line <= rf.line;
		end
		if (load) begin
			inst <= src_line[addr_q[`OFFSET_MSB:`OFFSET_LSB]*`WORD_W +: `WORD_W];
		end
	end

endmodule

// ==== hdl/icache_data_way.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_data_way (
	input logic clk,
	input logic en,
	input logic we,
	input logic [`INDEX_W-1:0] index,
	input logic [`LINE_W-1:0] wdata,
	output logic [`LINE_W-1:0] rdata
);

	logic [`LINE_W-1:0] mem [`SETS];

	// single port. a read returns data on the cycle after en and holds it
	// while en stays low, so a stalled lookup keeps its line.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				rdata <= wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

// ==== hdl/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

	// controller states. LOOKUP_HIT means the data RAM output holds an accepted hit.
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP_HIT,
		REFILL,
		RESPOND_MISS
	} ctrl_state_t;

	// refill engine states, one APB transfer per SETUP/ACCESS pair.
	typedef enum logic [1:0] {
		R_IDLE,
		R_SETUP,
		R_ACCESS,
		R_DONE
	} refill_state_t;

	// one-hot way vector.
	typedef logic [`WAYS-1:0] way_sel_t;

endpackage

// ==== hdl/icache_refill.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_refill (
	input logic clk,
	input logic rst,
	icache_refill_if.refill ctl,
	output logic [`ADDR_W-1:0] paddr,
	output logic psel,
	output logic penable,
	input logic [`WORD_W-1:0] prdata,
	input logic pready
);

	import icache_pkg::*;

	refill_state_t state;
	logic [`OFFSET_MSB-`OFFSET_LSB:0] cnt;
	logic [`ADDR_W-`INDEX_LSB-1:0] base;
	logic [`LINE_W-1:0] line_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= R_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				R_IDLE: begin
					if (ctl.start) begin
						state <= R_SETUP;
						cnt <= '0;
					end
				end
				R_SETUP: begin
					state <= R_ACCESS;
				end
				R_ACCESS: begin
					if (pready) begin
						cnt <= cnt + 1'b1;
						if (cnt == `WORDS_PER_LINE - 1) begin
							state <= R_DONE;
						end else begin
							state <= R_SETUP;
						end
					end
				end
				default: begin
					state <= R_IDLE;
				end
			endcase
		end
	end

	// words arrive in ascending order, so shifting in from the top leaves
	// word 0 in the low bits after the last transfer.
	always_ff @(posedge clk) begin
		if (state == R_IDLE && ctl.start) begin
			base <= ctl.addr[`ADDR_W-1:`INDEX_LSB];
		end
		if (state == R_ACCESS && pready) begin
			line_q <= {prdata, line_q[`LINE_W-1:`WORD_W]};
		end
	end

	assign paddr = {base, cnt, {`OFFSET_LSB{1'b0}}};
	assign psel = (state == R_SETUP) || (state == R_ACCESS);
	assign penable = (state == R_ACCESS);

	assign ctl.busy = (state != R_IDLE);
	assign ctl.done = (state == R_DONE);
	assign ctl.line = line_q;

endmodule

// ==== hdl/icache_refill_if.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

interface icache_refill_if;

	logic start;
	logic [`ADDR_W-1:0] addr;
	logic done;
	logic [`LINE_W-1:0] line;
	logic busy;

	// start and done are single-cycle pulses.
	modport ctrl (
		output start,
		output addr,
		input done,
		input line,
		input busy
	);

	modport refill (
		input start,
		input addr,
		output done,
		output line,
		output busy
	);

endinterface

// ==== hdl/icache_tag_array.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_tag_array (
	input logic clk,
	input logic rst,
	input logic [`ADDR_W-1:0] lookup_addr,
	input logic fill,
	input icache_pkg::way_sel_t fill_way,
	input logic [`ADDR_W-1:0] fill_addr,
	output icache_pkg::way_sel_t hit_way,
	output icache_pkg::way_sel_t victim_way
);

	import icache_pkg::*;

	logic [`TAG_W-1:0] tags [`WAYS][`SETS];
	logic [`SETS-1:0] valid [`WAYS];
	way_sel_t victim;

	logic [`INDEX_W-1:0] lookup_index;
	logic [`TAG_W-1:0] lookup_tag;
	logic [`INDEX_W-1:0] fill_index;
	logic [`TAG_W-1:0] fill_tag;

	assign lookup_index = lookup_addr[`INDEX_LSB +: `INDEX_W];
	assign lookup_tag = lookup_addr[`TAG_LSB +: `TAG_W];
	assign fill_index = fill_addr[`INDEX_LSB +: `INDEX_W];
	assign fill_tag = fill_addr[`TAG_LSB +: `TAG_W];

	// all four ways are compared in parallel.
	always_comb begin
		for (int w = 0; w < `WAYS; w++) begin
			hit_way[w] = valid[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < `WAYS; w++) begin
				if (fill_way[w]) begin
					valid[w][fill_index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][fill_index] <= fill_tag;
				end
			end
		end
	end

	// the victim rotates once per fill, no matter which set was filled.
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_sel_t'(1);
		end else if (fill) begin
			victim <= {victim[`WAYS-2:0], victim[`WAYS-1]};
		end
	end

	assign victim_way = victim;

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_top (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input logic [`ADDR_W-1:0] fetch_addr,
	output logic fetch_ready,
	output logic inst_valid,
	output logic [`WORD_W-1:0] inst,
	input logic inst_ready,
	input logic flush,
	output logic [`ADDR_W-1:0] paddr,
	output logic psel,
	output logic penable,
	input logic [`WORD_W-1:0] prdata,
	input logic pready
);

	import icache_pkg::*;

	way_sel_t hit_way;
	way_sel_t victim_way;
	way_sel_t way_en;
	way_sel_t fill_way;
	logic way_we;
	logic fill;
	logic [`INDEX_W-1:0] ram_index;
	logic [`ADDR_W-1:0] fill_addr;
	logic [`LINE_W-1:0] line_wdata;
	logic [`LINE_W-1:0] rdata0;
	logic [`LINE_W-1:0] rdata1;
	logic [`LINE_W-1:0] rdata2;
	logic [`LINE_W-1:0] rdata3;

	icache_refill_if rf_if ();

	icache_tag_array u_tag_array (
		.clk(clk),
		.rst(rst),
		.lookup_addr(fetch_addr),
		.fill(fill),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.hit_way(hit_way),
		.victim_way(victim_way)
	);

	icache_data_way u_way0 (.clk(clk), .en(way_en[0]), .we(way_we), .index(ram_index),
		.wdata(line_wdata), .rdata(rdata0));
	icache_data_way u_way1 (.clk(clk), .en(way_en[1]), .we(way_we), .index(ram_index),
		.wdata(line_wdata), .rdata(rdata1));
	icache_data_way u_way2 (.clk(clk), .en(way_en[2]), .we(way_we), .index(ram_index),
		.wdata(line_wdata), .rdata(rdata2));
	icache_data_way u_way3 (.clk(clk), .en(way_en[3]), .we(way_we), .index(ram_index),
		.wdata(line_wdata), .rdata(rdata3));

	icache_refill u_refill (
		.clk(clk),
		.rst(rst),
		.ctl(rf_if.refill),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.prdata(prdata),
		.pready(pready)
	);

	icache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.inst_ready(inst_ready),
		.flush(flush),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.rdata0(rdata0),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.rdata3(rdata3),
		.rf(rf_if.ctrl),
		.fetch_ready(fetch_ready),
		.inst_valid(inst_valid),
		.inst(inst),
		.way_en(way_en),
		.way_we(way_we),
		.ram_index(ram_index),
		.fill(fill),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.line_wdata(line_wdata)
	);

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_refill_if.sv
hdl/icache_tag_array.sv
hdl/icache_data_way.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_chk.sv
testbench/tb_icache.sv

// ==== testbench/icache_chk.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_chk (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic [`ADDR_W-1:0] paddr,
	input logic inst_valid,
	input logic inst_ready,
	input logic [`WORD_W-1:0] inst
);

	int fail_count = 0;

	a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
	else begin
		fail_count++;
		$error("penable high without psel");
	end

	// every transfer opens with a setup cycle.
	a_setup: assert property (@(posedge clk) disable iff (rst) $rose(psel) |-> !penable)
	else begin
		fail_count++;
		$error("psel rose together with penable");
	end

	a_paddr: assert property (@(posedge clk) disable iff (rst)
		psel && !(penable && pready) |=> $stable(paddr))
	else begin
		fail_count++;
		$error("paddr changed inside an APB transfer");
	end

	a_inst_hold: assert property (@(posedge clk) disable iff (rst)
		inst_valid && !inst_ready |=> $stable(inst))
	else begin
		fail_count++;
		$error("inst changed while the response was stalled");
	end

endmodule

bind icache_top icache_chk u_chk (
	.clk(clk),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.paddr(paddr),
	.inst_valid(inst_valid),
	.inst_ready(inst_ready),
	.inst(inst)
);

// ==== testbench/tb_icache.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module tb_icache;

	logic clk;
	logic rst;
	logic fetch_valid;
	logic [`ADDR_W-1:0] fetch_addr;
	logic fetch_ready;
	logic inst_valid;
	logic [`WORD_W-1:0] inst;
	logic inst_ready;
	logic flush;
	logic [`ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic [`WORD_W-1:0] prdata;
	logic pready;

	logic [15:0] lfsr = 16'd28912;
	logic [`TAG_W-1:0] model_tag [`WAYS][`SETS];
	bit model_valid [`WAYS][`SETS];
	int victim = 0;
	logic [`ADDR_W-1:0] resp_q [$];
	logic [`ADDR_W-1:0] apb_q [$];

	bit req_active = 0;
	logic [`ADDR_W-1:0] req_addr = '0;
	bit rand_mode = 0;
	bit flush_req = 0;
	bit hold_ready = 0;
	int apb_wait = 0;
	bit hit_pending = 0;
	bit hit_due = 0;
	bit prev_hold = 0;
	bit prev_flush = 0;
	logic [`WORD_W-1:0] prev_inst;

	icache_top u_icache_top (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_ready(inst_ready),
		.flush(flush),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.prdata(prdata),
		.pready(pready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic next_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 16'hb400;
		end
		return out;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	// memory contents: upper half of the word address inverted, lower half as is.
	function automatic logic [`WORD_W-1:0] mem_word(input logic [`ADDR_W-1:0] a);
		logic [31:0] w;
		w = a >> 2;
		return {~w[31:16], w[15:0]};
	endfunction

	function automatic logic [`ADDR_W-1:0] make_addr(input logic [`TAG_W-1:0] tag,
		input logic [`INDEX_W-1:0] set, input logic [1:0] off);
		return {tag, set, off, 2'b00};
	endfunction

	// eight tags over two sets, so lines keep getting evicted.
	function automatic logic [`ADDR_W-1:0] random_addr();
		logic [`INDEX_W-1:0] set;
		logic [`TAG_W-1:0] tag;
		set = random_bits(1) ? 6'd17 : 6'd3;
		tag = 22'h2a0 + 22'(random_bits(3));
		return make_addr(tag, set, 2'(random_bits(2)));
	endfunction

	// a miss fills the model at once, since nothing else is accepted before the refill ends.
	function automatic bit model_access(input logic [`ADDR_W-1:0] a);
		logic [`INDEX_W-1:0] set;
		logic [`TAG_W-1:0] tag;
		set = a[`INDEX_LSB +: `INDEX_W];
		tag = a[`TAG_LSB +: `TAG_W];
		for (int w = 0; w < `WAYS; w++) begin
			if (model_valid[w][set] && model_tag[w][set] == tag) begin
				return 1'b1;
			end
		end
		model_tag[victim][set] = tag;
		model_valid[victim][set] = 1'b1;
		victim = (victim + 1) % `WAYS;
		return 1'b0;
	endfunction

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			fail_stop($sformatf("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act));
		end
	endtask

	// drive on the falling edge, then look at the settled cycle and book the next edge.
	task automatic tick();
		bit hit;
		logic [`ADDR_W-1:0] a;
		@(negedge clk);
		if (psel && !penable) begin
			apb_wait = random_bits(2);
			pready = 1'b0;
		end else if (psel && penable) begin
			pready = (apb_wait == 0);
			prdata = mem_word(paddr);
			if (apb_wait > 0) begin
				apb_wait--;
			end
		end else begin
			pready = 1'b0;
		end
		if (rand_mode && !req_active && random_bits(1)) begin
			req_addr = random_addr();
			req_active = 1'b1;
		end
		fetch_valid = req_active;
		fetch_addr = req_addr;
		inst_ready = rand_mode ? (random_bits(2) != 0) : !hold_ready;
		flush = flush_req || (rand_mode && random_bits(5) == 0);
		flush_req = 1'b0;
		#1;
		if (prev_hold) begin
			check_equal("inst_valid", 1, inst_valid);
			check_equal("inst", prev_inst, inst);
		end
		if (prev_flush) begin
			check_equal("inst_valid", 0, inst_valid);
		end
		if (hit_due) begin
			check_equal("inst_valid", 1, inst_valid);
		end
		if (inst_valid && !inst_ready) begin
			check_equal("fetch_ready", 0, fetch_ready);
		end
		if (inst_valid && inst_ready) begin
			if (resp_q.size() == 0) begin
				fail_stop("a response came out with no request outstanding");
			end else begin
				a = resp_q.pop_front();
				check_equal("inst", mem_word(a), inst);
			end
		end
		if (psel && penable && pready) begin
			if (apb_q.size() == 0) begin
				fail_stop("an APB read happened with no miss outstanding");
			end else begin
				check_equal("paddr", apb_q.pop_front(), paddr);
			end
		end
		hit_due = hit_pending && !flush && (!inst_valid || inst_ready);
		if (flush || hit_due) begin
			hit_pending = 1'b0;
		end
		if (flush) begin
			resp_q.delete();
		end
		if (fetch_valid && fetch_ready) begin
			hit = model_access(fetch_addr);
			resp_q.push_back(fetch_addr);
			if (hit) begin
				hit_pending = 1'b1;
			end else begin
				for (int i = 0; i < `WORDS_PER_LINE; i++) begin
					apb_q.push_back({fetch_addr[`ADDR_W-1:`INDEX_LSB], 4'(i * 4)});
				end
			end
			req_active = 1'b0;
		end
		prev_hold = inst_valid && !inst_ready && !flush;
		prev_flush = flush;
		prev_inst = inst;
	endtask

	task automatic send_request(input logic [`ADDR_W-1:0] a);
		int n;
		req_addr = a;
		req_active = 1'b1;
		n = 0;
		while (req_active) begin
			if (n == 100) begin
				fail_stop("timeout: a fetch request was never accepted");
			end else begin
				tick();
				n++;
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (req_active || resp_q.size() != 0 || apb_q.size() != 0 || psel) begin
			if (n == 400) begin
				fail_stop("timeout: responses or APB reads still outstanding");
			end else begin
				tick();
				n++;
			end
		end
	endtask

	initial begin
		int n;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		inst_ready = 1'b0;
		flush = 1'b0;
		prdata = '0;
		pready = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		check_equal("inst_valid", 0, inst_valid);
		check_equal("psel", 0, psel);
		check_equal("fetch_ready", 1, fetch_ready);

		// five lines in set 3 overflow the four ways and push out the first one.
		for (int t = 0; t < 5; t++) begin
			send_request(make_addr(22'h40 + 22'(t), 6'd3, 2'(t)));
			wait_drain();
		end
		send_request(make_addr(22'h40, 6'd3, 2'd1));
		wait_drain();
		send_request(make_addr(22'h44, 6'd3, 2'd2));
		wait_drain();

		// stall a hit, then flush it away.
		hold_ready = 1'b1;
		send_request(make_addr(22'h44, 6'd3, 2'd3));
		n = 0;
		while (!inst_valid) begin
			if (n == 100) begin
				fail_stop("timeout: no response for the stalled request");
			end else begin
				tick();
				n++;
			end
		end
		repeat (3) tick();
		flush_req = 1'b1;
		tick();
		hold_ready = 1'b0;
		repeat (2) tick();
		wait_drain();

		// flush in the middle of a refill; the line must still be cached.
		send_request(make_addr(22'h50, 6'd17, 2'd0));
		n = 0;
		while (!psel) begin
			if (n == 20) begin
				fail_stop("timeout: the miss did not start an APB read");
			end else begin
				tick();
				n++;
			end
		end
		flush_req = 1'b1;
		wait_drain();
		send_request(make_addr(22'h50, 6'd17, 2'd2));
		wait_drain();

		rand_mode = 1'b1;
		repeat (4000) tick();
		rand_mode = 1'b0;
		wait_drain();
		repeat (2) tick();

		if (u_icache_top.u_chk.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("protocol assertions failed %0d times", u_icache_top.u_chk.fail_count);
			$display("Errors found");
		end
		$finish;
	end

endmodule
